//--- rtl/bus_pkg.sv
package bus_pkg;

  // --------------------------------------------------
  // System bus widths
  // --------------------------------------------------

  // Byte address as seen by the core
  typedef logic [31:0] addr_t;

  // One bus word
  typedef logic [31:0] data_t;

  // --------------------------------------------------
  // Fixed responses
  // --------------------------------------------------

  // Payload of every error answer, easy to spot in a dump
  localparam data_t ErrRspData = 32'hBADC_AB1E;

endpackage

//--- rtl/user_pkg.sv
package user_pkg;

  // --------------------------------------------------
  // Subordinates of the user domain
  // --------------------------------------------------

  localparam int unsigned NumSbr = 3;

  // Error subordinate is index 0 so that it is the decoder default
  typedef enum logic [1:0] {
    UserError    = 2'd0,
    UserRom      = 2'd1,
    UserNeopixel = 2'd2
  } sbr_idx_t;

  // --------------------------------------------------
  // Address map, end addresses are exclusive
  // --------------------------------------------------

  localparam bus_pkg::addr_t UserBase = 32'h2000_0000;
  localparam bus_pkg::addr_t RomBase  = UserBase;
  localparam bus_pkg::addr_t RomEnd   = UserBase + 32'h0000_1000;
  localparam bus_pkg::addr_t NeoBase  = UserBase + 32'h0000_1000;
  localparam bus_pkg::addr_t NeoEnd   = UserBase + 32'h0000_2000;

  // Neopixel register offsets inside its 4 KiB window
  localparam logic [11:0] NeoRegData   = 12'h000;
  localparam logic [11:0] NeoRegStatus = 12'h004;
  localparam logic [11:0] NeoRegCtrl   = 12'h008;

  // One LED worth of colour, sent G then R then B
  typedef logic [23:0] pixel_t;

  // "USER DOMAIN ROM!" with the first character in byte 0
  localparam bus_pkg::data_t RomWords [4] = '{
    32'h5245_5355,
    32'h4D4F_4420,
    32'h204E_4941,
    32'h214D_4F52
  };

  // Interrupt lines towards the core, bit 0 is the neopixel
  localparam int unsigned NumIrqs = 4;

endpackage

//--- rtl/neopixel_fifo.sv
`timescale 1ns/100ps

module neopixel_fifo #(
  parameter int unsigned Depth = 8
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           push_i,
  input  user_pkg::pixel_t               pixel_i,
  input  logic                           pop_i,
  output user_pkg::pixel_t               pixel_o,
  output logic                           empty_o,
  output logic                           full_o,
  output logic [$clog2(Depth + 1)-1:0]   level_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned LvlW = $clog2(Depth + 1);

  user_pkg::pixel_t mem [Depth];
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic [LvlW-1:0]  level_q;
  logic             do_push;
  logic             do_pop;

  // Push into a full buffer is dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign empty_o = (level_q == '0);
  assign full_o  = (level_q == LvlW'(Depth));
  assign level_o = level_q;

  // Head word is always presented
  assign pixel_o = mem[rd_ptr_q];

  // Pointers wrap at Depth, level tracks occupancy
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together keep the level
      if (do_push && !do_pop) begin
        level_q <= level_q + 1'b1;
      end else if (do_pop && !do_push) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= pixel_i;
    end
  end

  // Serializer must check empty before it pops
  assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o);

endmodule

//--- rtl/neopixel_ser.sv
`timescale 1ns/100ps

module neopixel_ser #(
  parameter int unsigned BitCycles   = 125,
  parameter int unsigned HighOne     = 80,
  parameter int unsigned HighZero    = 40,
  parameter int unsigned LatchCycles = 6000
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             en_i,
  input  logic             empty_i,
  input  user_pkg::pixel_t pixel_i,
  output logic             pop_o,
  output logic             busy_o,
  output logic             data_o
);

  localparam int unsigned CntMax = (LatchCycles > BitCycles) ? LatchCycles : BitCycles;
  localparam int unsigned CntW   = $clog2(CntMax + 1);

  typedef enum logic [1:0] {
    Idle,
    Shift,
    Latch
  } state_e;

  state_e           state_q;
  logic             start_q;
  user_pkg::pixel_t shreg_q;
  logic [4:0]       bit_cnt_q;
  logic [CntW-1:0]  cyc_cnt_q;
  logic [CntW-1:0]  cyc_nxt;
  logic [CntW-1:0]  high_cycles;
  logic             bit_end;
  logic             pixel_end;
  logic             more;

  // --------------------------------------------------
  // Bit timing
  // --------------------------------------------------

  assign cyc_nxt     = cyc_cnt_q + 1'b1;
  assign high_cycles = shreg_q[23] ? CntW'(HighOne) : CntW'(HighZero);
  assign bit_end     = (cyc_cnt_q == CntW'(BitCycles - 1));
  assign pixel_end   = bit_end && (bit_cnt_q == 5'd23);
  assign more        = en_i & ~empty_i;

  // Take a pixel after the idle arm cycle, or back to back at pixel end
  assign pop_o  = (state_q == Idle && start_q) || (state_q == Shift && pixel_end && more);
  assign busy_o = (state_q != Idle) || start_q;

  // --------------------------------------------------
  // Control FSM
  // --------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= Idle;
      start_q   <= 1'b0;
      data_o    <= 1'b0;
      bit_cnt_q <= '0;
      cyc_cnt_q <= '0;
    end else begin
      start_q <= 1'b0;
      case (state_q)
        Idle: begin
          data_o <= 1'b0;
          if (start_q) begin
            // Pixel loads now, line rises with the first bit
            state_q   <= Shift;
            data_o    <= 1'b1;
            bit_cnt_q <= '0;
            cyc_cnt_q <= '0;
          end else if (more) begin
            start_q <= 1'b1;
          end
        end
        Shift: begin
          if (!bit_end) begin
            cyc_cnt_q <= cyc_nxt;
            data_o    <= (cyc_nxt < high_cycles);
          end else begin
            cyc_cnt_q <= '0;
            if (!pixel_end) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              data_o    <= 1'b1;
            end else if (more) begin
              // Next pixel without gap
              bit_cnt_q <= '0;
              data_o    <= 1'b1;
            end else begin
              state_q <= Latch;
              data_o  <= 1'b0;
            end
          end
        end
        Latch: begin
          // Low gap makes the LEDs take their colours
          data_o <= 1'b0;
          if (cyc_cnt_q == CntW'(LatchCycles - 1)) begin
            state_q   <= Idle;
            cyc_cnt_q <= '0;
          end else begin
            cyc_cnt_q <= cyc_nxt;
          end
        end
        default: state_q <= Idle;
      endcase
    end
  end

  // Pixel shift register, MSB first
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      shreg_q <= pixel_i;
    end else if (state_q == Shift && bit_end) begin
      shreg_q <= {shreg_q[22:0], 1'b0};
    end
  end

  // Line stays low outside a pixel
  assert property (@(posedge clk_i) disable iff (rst_i) data_o |-> (state_q == Shift));

endmodule

//--- rtl/neopixel.sv
`timescale 1ns/100ps

module neopixel #(
  parameter int unsigned FifoDepth   = 8,
  parameter int unsigned BitCycles   = 125,
  parameter int unsigned HighOne     = 80,
  parameter int unsigned HighZero    = 40,
  parameter int unsigned LatchCycles = 6000
) (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           sbr_req_i,
  input  logic           sbr_we_i,
  input  bus_pkg::addr_t sbr_addr_i,
  input  bus_pkg::data_t sbr_wdata_i,
  output logic           sbr_rvalid_o,
  output bus_pkg::data_t sbr_rdata_o,
  output logic           sbr_err_o,
  output logic           irq_o,
  output logic           data_o
);

  localparam int unsigned LvlW = $clog2(FifoDepth + 1);

  logic [11:0]      offset;
  logic             sel_data;
  logic             sel_status;
  logic             sel_ctrl;
  logic             push;
  logic             pop;
  logic             empty;
  logic             full;
  logic             busy;
  logic [LvlW-1:0]  level;
  user_pkg::pixel_t fifo_pixel;
  logic             en_q;
  logic             irq_en_q;
  logic             overflow_q;
  bus_pkg::data_t   rdata_d;
  logic             err_d;

  // --------------------------------------------------
  // Register decode
  // --------------------------------------------------

  assign offset     = sbr_addr_i[11:0];
  assign sel_data   = (offset == user_pkg::NeoRegData);
  assign sel_status = (offset == user_pkg::NeoRegStatus);
  assign sel_ctrl   = (offset == user_pkg::NeoRegCtrl);
  assign push       = sbr_req_i & sbr_we_i & sel_data;

  // Read mux, unknown offsets flag an error
  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    if (sel_status) begin
      rdata_d[4:0] = 5'(level);
      rdata_d[8]   = overflow_q;
      rdata_d[9]   = busy;
    end else if (sel_ctrl) begin
      rdata_d[1:0] = {irq_en_q, en_q};
    end else if (!sel_data) begin
      err_d = 1'b1;
    end
    // Writes answer with zero
    if (sbr_we_i) begin
      rdata_d = '0;
    end
  end

  // Control state and response handshake
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_q         <= 1'b0;
      irq_en_q     <= 1'b0;
      overflow_q   <= 1'b0;
      sbr_rvalid_o <= 1'b0;
      sbr_err_o    <= 1'b0;
    end else begin
      sbr_rvalid_o <= sbr_req_i;
      sbr_err_o    <= sbr_req_i & err_d;
      // Sticky until cleared through CTRL bit 8
      if (push && full) begin
        overflow_q <= 1'b1;
      end
      if (sbr_req_i && sbr_we_i && sel_ctrl) begin
        en_q     <= sbr_wdata_i[0];
        irq_en_q <= sbr_wdata_i[1];
        if (sbr_wdata_i[8]) begin
          overflow_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sbr_req_i) begin
      sbr_rdata_o <= rdata_d;
    end
  end

  // FIFO ran dry
  assign irq_o = irq_en_q & empty;

  // --------------------------------------------------
  // Pixel path
  // --------------------------------------------------

  neopixel_fifo #(
    .Depth ( FifoDepth )
  ) i_fifo (
    .clk_i   ( clk_i              ),
    .rst_i   ( rst_i              ),
    .push_i  ( push               ),
    .pixel_i ( sbr_wdata_i[23:0]  ),
    .pop_i   ( pop                ),
    .pixel_o ( fifo_pixel         ),
    .empty_o ( empty              ),
    .full_o  ( full               ),
    .level_o ( level              )
  );

  neopixel_ser #(
    .BitCycles   ( BitCycles   ),
    .HighOne     ( HighOne     ),
    .HighZero    ( HighZero    ),
    .LatchCycles ( LatchCycles )
  ) i_ser (
    .clk_i   ( clk_i      ),
    .rst_i   ( rst_i      ),
    .en_i    ( en_q       ),
    .empty_i ( empty      ),
    .pixel_i ( fifo_pixel ),
    .pop_o   ( pop        ),
    .busy_o  ( busy       ),
    .data_o  ( data_o     )
  );

endmodule

//--- rtl/user_sbr_demux.sv
`timescale 1ns/100ps

module user_sbr_demux (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  // Upstream port from the core
  input  logic                                    req_i,
  input  logic                                    we_i,
  input  bus_pkg::addr_t                          addr_i,
  input  bus_pkg::data_t                          wdata_i,
  output logic                                    rvalid_o,
  output bus_pkg::data_t                          rdata_o,
  output logic                                    err_o,
  // Downstream ports, request fields shared by all subordinates
  output logic           [user_pkg::NumSbr-1:0]   sbr_req_o,
  output logic                                    sbr_we_o,
  output bus_pkg::addr_t                          sbr_addr_o,
  output bus_pkg::data_t                          sbr_wdata_o,
  input  logic           [user_pkg::NumSbr-1:0]   sbr_rvalid_i,
  input  bus_pkg::data_t [user_pkg::NumSbr-1:0]   sbr_rdata_i,
  input  logic           [user_pkg::NumSbr-1:0]   sbr_err_i
);

  user_pkg::sbr_idx_t sel_idx;
  user_pkg::sbr_idx_t rsp_idx_q;
  logic               rsp_pending_q;

  // --------------------------------------------------
  // Request side
  // --------------------------------------------------

  // Address decode, anything outside ROM and neopixel goes to error
  always_comb begin
    sel_idx = user_pkg::UserError;
    if (addr_i >= user_pkg::RomBase && addr_i < user_pkg::RomEnd) begin
      sel_idx = user_pkg::UserRom;
    end else if (addr_i >= user_pkg::NeoBase && addr_i < user_pkg::NeoEnd) begin
      sel_idx = user_pkg::UserNeopixel;
    end
  end

  // Strobe reaches only the selected subordinate
  always_comb begin
    sbr_req_o          = '0;
    sbr_req_o[sel_idx] = req_i;
  end

  // Request fields fan out unchanged
  assign sbr_we_o    = we_i;
  assign sbr_addr_o  = addr_i;
  assign sbr_wdata_o = wdata_i;

  // --------------------------------------------------
  // Response side
  // --------------------------------------------------

  // Remember who owes the answer in the next cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_pending_q <= 1'b0;
      rsp_idx_q     <= user_pkg::UserError;
    end else begin
      rsp_pending_q <= req_i;
      if (req_i) begin
        rsp_idx_q <= sel_idx;
      end
    end
  end

  // Route back the pending subordinate only
  assign rvalid_o = rsp_pending_q & sbr_rvalid_i[rsp_idx_q];
  assign rdata_o  = sbr_rdata_i[rsp_idx_q];
  assign err_o    = sbr_err_i[rsp_idx_q];

  // One target per request
  assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(sbr_req_o));

  // A subordinate may only answer for the request it was given
  for (genvar i = 0; i < user_pkg::NumSbr; i++) begin : gen_rsp_chk
    assert property (@(posedge clk_i) disable iff (rst_i)
      sbr_rvalid_i[i] |-> (rsp_pending_q && (rsp_idx_q == i)));
  end

endmodule

//--- rtl/user_rom.sv
`timescale 1ns/100ps

module user_rom (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           sbr_req_i,
  input  logic           sbr_we_i,
  input  bus_pkg::addr_t sbr_addr_i,
  input  bus_pkg::data_t sbr_wdata_i,
  output logic           sbr_rvalid_o,
  output bus_pkg::data_t sbr_rdata_o,
  output logic           sbr_err_o
);

  // Word index inside the 4 KiB window
  logic [9:0] word_idx;

  assign word_idx = sbr_addr_i[11:2];

  // Handshake and error flag, writes are refused
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sbr_rvalid_o <= 1'b0;
      sbr_err_o    <= 1'b0;
    end else begin
      sbr_rvalid_o <= sbr_req_i;
      sbr_err_o    <= sbr_req_i & sbr_we_i;
    end
  end

  // Read data, zero past the stored text and on writes
  // Write data is never stored here
  always_ff @(posedge clk_i) begin
    if (sbr_req_i) begin
      if (sbr_we_i || word_idx >= 10'd4) begin
        sbr_rdata_o <= '0;
      end else begin
        sbr_rdata_o <= user_pkg::RomWords[word_idx[1:0]];
      end
    end
  end

endmodule

//--- rtl/user_err_sbr.sv
`timescale 1ns/100ps

module user_err_sbr (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           sbr_req_i,
  input  logic           sbr_we_i,
  input  bus_pkg::addr_t sbr_addr_i,
  input  bus_pkg::data_t sbr_wdata_i,
  output logic           sbr_rvalid_o,
  output bus_pkg::data_t sbr_rdata_o,
  output logic           sbr_err_o
);

  // Same answer for reads and writes at any address
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sbr_rvalid_o <= 1'b0;
    end else begin
      sbr_rvalid_o <= sbr_req_i;
    end
  end

  // Error flag only on the answer cycle
  assign sbr_err_o   = sbr_rvalid_o;
  assign sbr_rdata_o = bus_pkg::ErrRspData;

  // No spontaneous answers
  assert property (@(posedge clk_i) disable iff (rst_i) sbr_rvalid_o |-> $past(sbr_req_i));

endmodule

//--- rtl/user_domain.sv
`timescale 1ns/100ps

module user_domain #(
  parameter int unsigned NeoFifoDepth   = 8,
  parameter int unsigned NeoBitCycles   = 125,
  parameter int unsigned NeoHighOne     = 80,
  parameter int unsigned NeoHighZero    = 40,
  parameter int unsigned NeoLatchCycles = 6000
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  bus_pkg::addr_t                addr_i,
  input  bus_pkg::data_t                wdata_i,
  output logic                          rvalid_o,
  output bus_pkg::data_t                rdata_o,
  output logic                          err_o,
  output logic                          neopixel_data_o,
  output logic [user_pkg::NumIrqs-1:0]  interrupts_o
);

  // Per-subordinate response lines, indexed by sbr_idx_t
  logic           [user_pkg::NumSbr-1:0] sbr_req;
  logic                                  sbr_we;
  bus_pkg::addr_t                        sbr_addr;
  bus_pkg::data_t                        sbr_wdata;
  logic           [user_pkg::NumSbr-1:0] sbr_rvalid;
  bus_pkg::data_t [user_pkg::NumSbr-1:0] sbr_rdata;
  logic           [user_pkg::NumSbr-1:0] sbr_err;
  logic                                  neo_irq;

  // --------------------------------------------------
  // Address decode and response routing
  // --------------------------------------------------

  user_sbr_demux i_demux (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .req_i        ( req_i      ),
    .we_i         ( we_i       ),
    .addr_i       ( addr_i     ),
    .wdata_i      ( wdata_i    ),
    .rvalid_o     ( rvalid_o   ),
    .rdata_o      ( rdata_o    ),
    .err_o        ( err_o      ),
    .sbr_req_o    ( sbr_req    ),
    .sbr_we_o     ( sbr_we     ),
    .sbr_addr_o   ( sbr_addr   ),
    .sbr_wdata_o  ( sbr_wdata  ),
    .sbr_rvalid_i ( sbr_rvalid ),
    .sbr_rdata_i  ( sbr_rdata  ),
    .sbr_err_i    ( sbr_err    )
  );

  // --------------------------------------------------
  // Subordinates
  // --------------------------------------------------

  // Default target for unmapped space
  user_err_sbr i_err (
    .clk_i        ( clk_i                             ),
    .rst_i        ( rst_i                             ),
    .sbr_req_i    ( sbr_req[user_pkg::UserError]      ),
    .sbr_we_i     ( sbr_we                            ),
    .sbr_addr_i   ( sbr_addr                          ),
    .sbr_wdata_i  ( sbr_wdata                         ),
    .sbr_rvalid_o ( sbr_rvalid[user_pkg::UserError]   ),
    .sbr_rdata_o  ( sbr_rdata[user_pkg::UserError]    ),
    .sbr_err_o    ( sbr_err[user_pkg::UserError]      )
  );

  // Identification text
  user_rom i_rom (
    .clk_i        ( clk_i                           ),
    .rst_i        ( rst_i                           ),
    .sbr_req_i    ( sbr_req[user_pkg::UserRom]      ),
    .sbr_we_i     ( sbr_we                          ),
    .sbr_addr_i   ( sbr_addr                        ),
    .sbr_wdata_i  ( sbr_wdata                       ),
    .sbr_rvalid_o ( sbr_rvalid[user_pkg::UserRom]   ),
    .sbr_rdata_o  ( sbr_rdata[user_pkg::UserRom]    ),
    .sbr_err_o    ( sbr_err[user_pkg::UserRom]      )
  );

  // LED chain driver
  neopixel #(
    .FifoDepth   ( NeoFifoDepth   ),
    .BitCycles   ( NeoBitCycles   ),
    .HighOne     ( NeoHighOne     ),
    .HighZero    ( NeoHighZero    ),
    .LatchCycles ( NeoLatchCycles )
  ) i_neopixel (
    .clk_i        ( clk_i                                ),
    .rst_i        ( rst_i                                ),
    .sbr_req_i    ( sbr_req[user_pkg::UserNeopixel]      ),
    .sbr_we_i     ( sbr_we                               ),
    .sbr_addr_i   ( sbr_addr                             ),
    .sbr_wdata_i  ( sbr_wdata                            ),
    .sbr_rvalid_o ( sbr_rvalid[user_pkg::UserNeopixel]   ),
    .sbr_rdata_o  ( sbr_rdata[user_pkg::UserNeopixel]    ),
    .sbr_err_o    ( sbr_err[user_pkg::UserNeopixel]      ),
    .irq_o        ( neo_irq                              ),
    .data_o       ( neopixel_data_o                      )
  );

  // Only line 0 is in use
  assign interrupts_o = {{(user_pkg::NumIrqs - 1){1'b0}}, neo_irq};

endmodule

//--- tests/tb_user_domain.sv
`timescale 1ns/100ps

module tb_user_domain;

  // Short pulse timing so that a pixel takes a few hundred clocks
  localparam int unsigned BitCycles   = 10;
  localparam int unsigned HighOne     = 7;
  localparam int unsigned HighZero    = 3;
  localparam int unsigned LatchCycles = 20;
  localparam int unsigned FifoDepth   = 8;
  localparam int unsigned MaxRows     = 64;

  // Address map and error word as the memory map defines them
  localparam bus_pkg::addr_t RomAddr   = 32'h2000_0000;
  localparam bus_pkg::addr_t NeoData   = 32'h2000_1000;
  localparam bus_pkg::addr_t NeoStatus = 32'h2000_1004;
  localparam bus_pkg::addr_t NeoCtrl   = 32'h2000_1008;
  localparam bus_pkg::data_t ErrWord   = 32'hBADC_AB1E;

  logic                          clk_i = 1'b0;
  logic                          rst_i;
  logic                          req_i;
  logic                          we_i;
  bus_pkg::addr_t                addr_i;
  bus_pkg::data_t                wdata_i;
  logic                          rvalid_o;
  bus_pkg::data_t                rdata_o;
  logic                          err_o;
  logic                          neopixel_data_o;
  logic [user_pkg::NumIrqs-1:0]  interrupts_o;

  // Stimulus table, one bus access per row
  logic             tbl_we    [MaxRows];
  bus_pkg::addr_t   tbl_addr  [MaxRows];
  bus_pkg::data_t   tbl_wdata [MaxRows];
  bus_pkg::data_t   tbl_rdata [MaxRows];
  logic             tbl_err   [MaxRows];
  int unsigned      row_cnt   = 0;
  int unsigned      row_first = 0;

  // Pixels in the order they should leave the line
  user_pkg::pixel_t pix_q [$];
  integer           seed = 32'hc0e8f894;
  bus_pkg::data_t   rnd_word;

  user_domain #(
    .NeoFifoDepth   ( FifoDepth   ),
    .NeoBitCycles   ( BitCycles   ),
    .NeoHighOne     ( HighOne     ),
    .NeoHighZero    ( HighZero    ),
    .NeoLatchCycles ( LatchCycles )
  ) DUT (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .req_i           ( req_i           ),
    .we_i            ( we_i            ),
    .addr_i          ( addr_i          ),
    .wdata_i         ( wdata_i         ),
    .rvalid_o        ( rvalid_o        ),
    .rdata_o         ( rdata_o         ),
    .err_o           ( err_o           ),
    .neopixel_data_o ( neopixel_data_o ),
    .interrupts_o    ( interrupts_o    )
  );

  always #5 clk_i = ~clk_i;

  // --------------------------------------------------
  // Error reporting and compares
  // --------------------------------------------------

  task automatic abort_run(string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(string name, bus_pkg::data_t got, bus_pkg::data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_pixel(string name, user_pkg::pixel_t got, user_pkg::pixel_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // --------------------------------------------------
  // Table handling
  // --------------------------------------------------

  // ASCII text packed four characters per word, first one in byte 0
  function automatic bus_pkg::data_t rom_text_word(int unsigned idx);
    string txt = "USER DOMAIN ROM!";
    return {txt[4*idx+3], txt[4*idx+2], txt[4*idx+1], txt[4*idx]};
  endfunction

  task automatic add_row(logic we, bus_pkg::addr_t addr, bus_pkg::data_t wdata,
                         bus_pkg::data_t exp_rdata, logic exp_err);
    tbl_we[row_cnt]    = we;
    tbl_addr[row_cnt]  = addr;
    tbl_wdata[row_cnt] = wdata;
    tbl_rdata[row_cnt] = exp_rdata;
    tbl_err[row_cnt]   = exp_err;
    row_cnt++;
  endtask

  // Issue the new rows back to back, each answer checked one cycle later
  task automatic run_table();
    int unsigned n;
    int unsigned r;
    n = row_cnt - row_first;
    for (int unsigned i = 0; i <= n; i++) begin
      @(posedge clk_i);
      if (i < n) begin
        r = row_first + i;
        req_i   <= 1'b1;
        we_i    <= tbl_we[r];
        addr_i  <= tbl_addr[r];
        wdata_i <= tbl_wdata[r];
      end else begin
        req_i <= 1'b0;
        we_i  <= 1'b0;
      end
      if (i > 0) begin
        r = row_first + i - 1;
        @(negedge clk_i);
        check_bit("rvalid_o", rvalid_o, 1'b1);
        check_word("rdata_o", rdata_o, tbl_rdata[r]);
        check_bit("err_o", err_o, tbl_err[r]);
      end
    end
    row_first = row_cnt;
  endtask

  // --------------------------------------------------
  // One-wire decoder
  // --------------------------------------------------

  // High time picks the bit value, MSB arrives first
  task automatic decode_pixels(int unsigned count);
    user_pkg::pixel_t got;
    int unsigned      high;
    int unsigned      waited;
    for (int unsigned p = 0; p < count; p++) begin
      got = '0;
      for (int b = 0; b < 24; b++) begin
        waited = 0;
        while (neopixel_data_o !== 1'b1) begin
          @(negedge clk_i);
          waited++;
          if (waited > BitCycles + LatchCycles) begin
            abort_run("timeout while waiting for a bit to start on neopixel_data_o");
          end
        end
        high = 0;
        while (neopixel_data_o === 1'b1) begin
          @(negedge clk_i);
          high++;
          if (high > BitCycles) begin
            abort_run("neopixel_data_o stayed high longer than a bit period");
          end
        end
        if (high == HighOne) begin
          got = {got[22:0], 1'b1};
        end else if (high == HighZero) begin
          got = {got[22:0], 1'b0};
        end else begin
          abort_run($sformatf("bit high time of %0d clocks is no valid code", high));
        end
      end
      check_pixel("neopixel pixel", got, pix_q.pop_front());
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    int unsigned waited;
    rst_i   = 1'b1;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_bit("rvalid_o", rvalid_o, 1'b0);
    check_bit("err_o", err_o, 1'b0);
    check_bit("neopixel_data_o", neopixel_data_o, 1'b0);
    check_word("interrupts_o", 32'(interrupts_o), 32'h0);

    // ROM text, a word past it, and a refused write
    for (int unsigned w = 0; w < 4; w++) begin
      add_row(1'b0, RomAddr + 4 * w, '0, rom_text_word(w), 1'b0);
    end
    add_row(1'b0, RomAddr + 32'h14, '0, 32'h0, 1'b0);
    add_row(1'b1, RomAddr, 32'h1234_5678, 32'h0, 1'b1);
    // Unmapped space below, above and far away
    add_row(1'b0, 32'h2000_2000, '0, ErrWord, 1'b1);
    add_row(1'b1, 32'h3000_0000, 32'hFFFF_0000, ErrWord, 1'b1);
    add_row(1'b0, 32'h1FFF_FFFC, '0, ErrWord, 1'b1);
    // Rotate over all three subordinates
    add_row(1'b0, RomAddr + 32'h4, '0, rom_text_word(1), 1'b0);
    add_row(1'b0, 32'h0000_0040, '0, ErrWord, 1'b1);
    add_row(1'b0, NeoStatus, '0, 32'h0, 1'b0);
    add_row(1'b0, RomAddr + 32'h8, '0, rom_text_word(2), 1'b0);
    add_row(1'b1, 32'h2000_3000, 32'h0, ErrWord, 1'b1);
    add_row(1'b0, NeoCtrl, '0, 32'h0, 1'b0);
    // Unknown register errors, STATUS write is ignored quietly
    add_row(1'b0, NeoData + 32'hC, '0, 32'h0, 1'b1);
    add_row(1'b1, NeoStatus, 32'hFFFF_FFFF, 32'h0, 1'b0);
    run_table();

    // Fill the FIFO with the serializer off, only Depth pixels fit
    for (int unsigned i = 0; i < 12; i++) begin
      rnd_word = $random(seed);
      add_row(1'b1, NeoData, rnd_word, 32'h0, 1'b0);
      if (i < FifoDepth) begin
        pix_q.push_back(rnd_word[23:0]);
      end
      if (i == 2) begin
        add_row(1'b0, NeoStatus, '0, 32'h0000_0003, 1'b0);
      end
    end
    add_row(1'b0, NeoStatus, '0, 32'h0000_0108, 1'b0);
    add_row(1'b1, NeoCtrl, 32'h0000_0100, 32'h0, 1'b0);
    add_row(1'b0, NeoStatus, '0, 32'h0000_0008, 1'b0);
    add_row(1'b1, NeoCtrl, 32'h0000_0002, 32'h0, 1'b0);
    add_row(1'b0, NeoCtrl, '0, 32'h0000_0002, 1'b0);
    add_row(1'b1, NeoCtrl, 32'h0000_0000, 32'h0, 1'b0);
    add_row(1'b0, NeoCtrl, '0, 32'h0000_0000, 1'b0);
    run_table();

    // Enable and watch the stored pixels leave in order
    add_row(1'b1, NeoCtrl, 32'h0000_0001, 32'h0, 1'b0);
    run_table();
    decode_pixels(FifoDepth);
    // Tail of the last bit plus the latch gap, bus idle throughout
    for (int unsigned k = 0; k < LatchCycles + BitCycles; k++) begin
      @(negedge clk_i);
      check_bit("neopixel_data_o", neopixel_data_o, 1'b0);
      check_bit("rvalid_o", rvalid_o, 1'b0);
    end
    add_row(1'b0, NeoStatus, '0, 32'h0000_0000, 1'b0);
    run_table();

    // Interrupt while enabled and dry
    add_row(1'b1, NeoCtrl, 32'h0000_0002, 32'h0, 1'b0);
    run_table();
    check_word("interrupts_o", 32'(interrupts_o), 32'h1);
    add_row(1'b1, NeoData, 32'h00AB_CDEF, 32'h0, 1'b0);
    run_table();
    check_word("interrupts_o", 32'(interrupts_o), 32'h0);
    // Serializer drains the pixel, line 0 comes back
    add_row(1'b1, NeoCtrl, 32'h0000_0003, 32'h0, 1'b0);
    run_table();
    waited = 0;
    while (interrupts_o[0] !== 1'b1) begin
      @(negedge clk_i);
      waited++;
      if (waited > 10) begin
        abort_run("timeout while waiting for the neopixel interrupt after draining");
      end
    end
    check_word("interrupts_o", 32'(interrupts_o), 32'h1);
    add_row(1'b1, NeoCtrl, 32'h0000_0001, 32'h0, 1'b0);
    add_row(1'b0, NeoCtrl, '0, 32'h0000_0001, 1'b0);
    run_table();
    check_word("interrupts_o", 32'(interrupts_o), 32'h0);

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- files.f
rtl/bus_pkg.sv
rtl/user_pkg.sv
rtl/neopixel_fifo.sv
rtl/neopixel_ser.sv
rtl/neopixel.sv
rtl/user_sbr_demux.sv
rtl/user_rom.sv
rtl/user_err_sbr.sv
rtl/user_domain.sv
tests/tb_user_domain.sv

//--- Bender.yml
package:
  name: user_domain

sources:
  - files:
      - rtl/bus_pkg.sv
      - rtl/user_pkg.sv
      - rtl/neopixel_fifo.sv
      - rtl/neopixel_ser.sv
      - rtl/neopixel.sv
      - rtl/user_sbr_demux.sv
      - rtl/user_rom.sv
      - rtl/user_err_sbr.sv
      - rtl/user_domain.sv
  - target: test
    files:
      - tests/tb_user_domain.sv
